//--- logic/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Data and address widths.
`define CSR_XLEN   32
`define CSR_ADDR_W 12

// Machine-mode trap setup and handling.
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTVAL    12'h343
`define CSR_ADDR_MIP      12'h344
`define CSR_ADDR_MTVEC    12'h305

// Lower halves of the performance counters.
`define CSR_ADDR_MCYCLE   12'hb00
`define CSR_ADDR_MINSTRET 12'hb02

`endif

//--- logic/csr_pkg.sv
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

   // Software access operations.
   typedef enum logic [1:0] {
      op_nop   = 2'd0,
      op_write = 2'd1,
      op_set   = 2'd2,
      op_clear = 2'd3
   } csr_op_e;

   // Internal register index, idx_none for an unmapped address.
   typedef enum logic [3:0] {
      idx_none     = 4'd0,
      idx_mscratch = 4'd1,
      idx_mepc     = 4'd2,
      idx_mcause   = 4'd3,
      idx_mtval    = 4'd4,
      idx_mip      = 4'd5,
      idx_mtvec    = 4'd6,
      idx_mcycle   = 4'd7,
      idx_minstret = 4'd8
   } csr_idx_e;

   typedef struct packed {
      csr_idx_e               idx;
      csr_op_e                op;
      logic [`CSR_XLEN-1:0]   wdata;
   } csr_req_t;

   typedef struct packed {
      logic                   trap;      // Trap strobe.
      logic [4:0]             src;       // Bit 4 marks an interrupt.
      logic                   misalign;
      logic [`CSR_XLEN-1:0]   pc;
      logic [`CSR_XLEN-1:0]   dmem_addr;
   } trap_t;

   typedef struct packed {
      logic [`CSR_XLEN-1:0]   mscratch;
      logic [`CSR_XLEN-1:0]   mepc;
      logic [`CSR_XLEN-1:0]   mcause;
      logic [`CSR_XLEN-1:0]   mtval;
      logic [`CSR_XLEN-1:0]   mip;
      logic [`CSR_XLEN-1:0]   mtvec;
   } csr_state_t;

   typedef struct packed {
      logic [`CSR_XLEN-1:0]   mcycle;
      logic [`CSR_XLEN-1:0]   minstret;
   } csr_count_t;

endpackage

`default_nettype wire

//--- logic/csr_decode.sv
`default_nettype none

`include "csr_settings.svh"

// Translates the architectural CSR address into the internal index.
module csr_decode (
   input  wire logic [`CSR_ADDR_W-1:0] addr,
   input  csr_pkg::csr_op_e            op,
   input  wire logic [`CSR_XLEN-1:0]   wdata,
   output csr_pkg::csr_req_t           req
);
   import csr_pkg::*;

   csr_idx_e idx;

   always_comb begin
      case (addr)
         `CSR_ADDR_MSCRATCH: begin
            idx = idx_mscratch;
         end
         `CSR_ADDR_MEPC: begin
            idx = idx_mepc;
         end
         `CSR_ADDR_MCAUSE: begin
            idx = idx_mcause;
         end
         `CSR_ADDR_MTVAL: begin
            idx = idx_mtval;
         end
         `CSR_ADDR_MIP: begin
            idx = idx_mip;
         end
         `CSR_ADDR_MTVEC: begin
            idx = idx_mtvec;
         end
         `CSR_ADDR_MCYCLE: begin
            idx = idx_mcycle;      // Read-only here.
         end
         `CSR_ADDR_MINSTRET: begin
            idx = idx_minstret;    // Read-only here.
         end
         default: begin
            idx = idx_none;        // Unmapped, reads zero.
         end
      endcase
   end

   // Opcode and data pass through untouched.
   always_comb begin
      req.idx   = idx;
      req.op    = op;
      req.wdata = wdata;
   end

endmodule

`default_nettype wire

//--- logic/csr_file.sv
`default_nettype none

`include "csr_settings.svh"

// Software-visible storage CSRs and trap capture.
module csr_file (
   input  wire logic             clk,
   input  wire logic             rst,
   input  csr_pkg::csr_req_t     req,
   input  csr_pkg::trap_t        trap_info,
   output csr_pkg::csr_state_t   state
);
   import csr_pkg::*;

   logic [`CSR_XLEN-1:0] cur_val;     // Current value of the addressed CSR.
   logic [`CSR_XLEN-1:0] wr_val;      // Value after the software operation.
   logic [`CSR_XLEN-1:0] cause_val;
   logic                 sw_wr;

   function automatic logic [`CSR_XLEN-1:0] apply_op(
      input logic [`CSR_XLEN-1:0] cur,
      input csr_op_e              opc,
      input logic [`CSR_XLEN-1:0] data
   );
      case (opc)
         op_write: return data;
         op_set:   return cur | data;
         op_clear: return cur & ~data;
         default:  return cur;
      endcase
   endfunction

   // One shared read-modify path for all registers.
   always_comb begin
      case (req.idx)
         idx_mscratch: cur_val = state.mscratch;
         idx_mepc:     cur_val = state.mepc;
         idx_mcause:   cur_val = state.mcause;
         idx_mtval:    cur_val = state.mtval;
         idx_mip:      cur_val = state.mip;
         idx_mtvec:    cur_val = state.mtvec;
         default:      cur_val = '0;
      endcase
   end

   assign wr_val = apply_op(cur_val, req.op, req.wdata);

   // A trap in progress drops the software access.
   assign sw_wr = !trap_info.trap;

   // Interrupt flag in the top bit, exception code in the low nibble.
   assign cause_val = {trap_info.src[4], {(`CSR_XLEN-5){1'b0}}, trap_info.src[3:0]};

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= '0;
      end else begin
         if (sw_wr) begin
            case (req.idx)
               idx_mscratch: state.mscratch <= wr_val;
               idx_mepc:     state.mepc     <= wr_val;
               idx_mcause:   state.mcause   <= wr_val;
               idx_mtval:    state.mtval    <= wr_val;
               idx_mip:      state.mip      <= wr_val;
               idx_mtvec:    state.mtvec    <= wr_val;
               default: begin
                  // Counters and unmapped addresses ignore writes.
               end
            endcase
         end

         if (trap_info.trap) begin
            state.mepc   <= trap_info.pc;
            state.mcause <= cause_val;
         end

         // Misaligned address wins over a write to mtval.
         if (trap_info.misalign) begin
            state.mtval <= trap_info.dmem_addr;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/csr_counters.sv
`default_nettype none

`include "csr_settings.svh"

// Cycle and retired-instruction counters.
module csr_counters (
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire logic             pipe_flush,
   input  wire logic             data_hazard,
   output csr_pkg::csr_count_t   counts
);
   import csr_pkg::*;

   logic [1:0]           flush_ctr;
   logic [1:0]           hazard_ctr;
   logic [`CSR_XLEN-1:0] next_minstret;
   logic                 instret;

   // Shadow counter step. A running count wins over a fresh load.
   function automatic logic [1:0] shadow_next(
      input logic [1:0] ctr,
      input logic       strobe
   );
      if (ctr != 2'd0) begin
         return ctr + 2'd1;   // Runs 2, 3, then wraps to 0.
      end else if (strobe) begin
         return 2'd2;
      end else begin
         return 2'd0;
      end
   endfunction

   // Cycles lost to a flush or a stall do not retire.
   assign instret = (hazard_ctr != 2'd3) && !pipe_flush && (flush_ctr == 2'd0);

   always_ff @(posedge clk) begin
      if (rst) begin
         flush_ctr  <= 2'd0;
         hazard_ctr <= 2'd0;
      end else begin
         flush_ctr  <= shadow_next(flush_ctr, pipe_flush);
         hazard_ctr <= shadow_next(hazard_ctr, data_hazard);
      end
   end

   // minstret trails next_minstret by one retired cycle.
   always_ff @(posedge clk) begin
      if (rst) begin
         counts.mcycle   <= '0;
         counts.minstret <= '0;
         next_minstret   <= `CSR_XLEN'd1;
      end else begin
         counts.mcycle <= counts.mcycle + 1'b1;
         if (instret) begin
            counts.minstret <= next_minstret;
            next_minstret   <= next_minstret + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/csr_read.sv
`default_nettype none

`include "csr_settings.svh"

// Registered read port plus the mepc and mtvec side outputs.
module csr_read (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  csr_pkg::csr_idx_e          idx,
   input  csr_pkg::csr_state_t        state,
   input  csr_pkg::csr_count_t        counts,
   output logic [`CSR_XLEN-1:0]       rdata,
   output logic [`CSR_XLEN-1:0]       mepc_rdata,
   output logic [`CSR_XLEN-1:0]       mtvec_rdata
);
   import csr_pkg::*;

   logic [`CSR_XLEN-1:0] sel;

   always_comb begin
      case (idx)
         idx_mscratch: sel = state.mscratch;
         idx_mepc:     sel = state.mepc;
         idx_mcause:   sel = state.mcause;
         idx_mtval:    sel = state.mtval;
         idx_mip:      sel = state.mip;
         idx_mtvec:    sel = state.mtvec;
         idx_mcycle:   sel = counts.mcycle;
         idx_minstret: sel = counts.minstret;
         default:      sel = '0;
      endcase
   end

   // Pre-write values, one edge late.
   always_ff @(posedge clk) begin
      if (rst) begin
         rdata       <= '0;
         mepc_rdata  <= '0;
         mtvec_rdata <= '0;
      end else begin
         rdata       <= sel;
         mepc_rdata  <= state.mepc;    // Return address for mret.
         mtvec_rdata <= state.mtvec;   // Trap vector for fetch.
      end
   end

endmodule

`default_nettype wire

//--- logic/csr_unit.sv
`default_nettype none

`include "csr_settings.svh"

// Machine-mode CSR unit top level.
module csr_unit (
   input  wire logic                  clk,
   input  wire logic                  rst,
   input  wire logic [`CSR_ADDR_W-1:0] addr,
   input  csr_pkg::csr_op_e           op,
   input  wire logic [`CSR_XLEN-1:0]  wdata,
   input  csr_pkg::trap_t             trap_info,
   input  wire logic                  pipe_flush,
   input  wire logic                  data_hazard,
   output logic [`CSR_XLEN-1:0]       rdata,
   output logic [`CSR_XLEN-1:0]       mepc_rdata,
   output logic [`CSR_XLEN-1:0]       mtvec_rdata
);
   import csr_pkg::*;

   csr_req_t   req;
   csr_state_t state;
   csr_count_t counts;

   csr_decode u_decode (
      .addr  (addr),
      .op    (op),
      .wdata (wdata),
      .req   (req)
   );

   csr_file u_file (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .trap_info (trap_info),
      .state     (state)
   );

   csr_counters u_counters (
      .clk         (clk),
      .rst         (rst),
      .pipe_flush  (pipe_flush),
      .data_hazard (data_hazard),
      .counts      (counts)
   );

   // Read side sees only the decoded index.
   csr_read u_read (
      .clk         (clk),
      .rst         (rst),
      .idx         (req.idx),
      .state       (state),
      .counts      (counts),
      .rdata       (rdata),
      .mepc_rdata  (mepc_rdata),
      .mtvec_rdata (mtvec_rdata)
   );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none

// Free-running clock and the initial synchronous reset.
module tb_clock (
   output logic clk,
   output logic rst
);
   localparam int HALF_PERIOD  = 5;
   localparam int RESET_CYCLES = 8;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;   // Released just after the eighth edge.
   end

endmodule

`default_nettype wire

//--- bench/csr_tb.sv
`default_nettype none

`include "csr_settings.svh"

module csr_tb;
   import csr_pkg::*;

   localparam int P_CYCLES = 300;   // Random cycles per phase.
   localparam int N_PHASES = 9;     // Five phases, then minstret at four densities.
   localparam int TIMEOUT  = (8 + N_PHASES * (P_CYCLES + 6) + 100) * 10;

   // Model slots of the storage CSRs.
   localparam logic [2:0] S_MEPC   = 3'd1;
   localparam logic [2:0] S_MCAUSE = 3'd2;
   localparam logic [2:0] S_MTVAL  = 3'd3;
   localparam logic [2:0] S_MTVEC  = 3'd5;

   logic                   clk;
   logic                   rst;
   logic [`CSR_ADDR_W-1:0] addr;
   csr_op_e                op;
   logic [`CSR_XLEN-1:0]   wdata;
   trap_t                  trap_info;
   logic                   pipe_flush;
   logic                   data_hazard;
   logic [`CSR_XLEN-1:0]   rdata;
   logic [`CSR_XLEN-1:0]   mepc_rdata;
   logic [`CSR_XLEN-1:0]   mtvec_rdata;

   logic [5:0][31:0] m_reg;         // mscratch, mepc, mcause, mtval, mip, mtvec.
   logic [31:0]      m_mcycle;
   logic [31:0]      m_minstret;
   logic [31:0]      m_next;
   logic [1:0]       m_fctr;
   logic [1:0]       m_hctr;
   logic [31:0]      lfsr_state;
   int unsigned      edge_count;
   int unsigned      errors;
   int unsigned      checks;
   string            test_name;

   tb_clock clock_gen (
      .clk (clk),
      .rst (rst)
   );

   csr_unit UUT (
      .clk         (clk),
      .rst         (rst),
      .addr        (addr),
      .op          (op),
      .wdata       (wdata),
      .trap_info   (trap_info),
      .pipe_flush  (pipe_flush),
      .data_hazard (data_hazard),
      .rdata       (rdata),
      .mepc_rdata  (mepc_rdata),
      .mtvec_rdata (mtvec_rdata)
   );

   // Edges since reset release, independent of the model.
   always @(posedge clk) begin
      if (rst) edge_count <= 0;
      else edge_count <= edge_count + 1;
   end

   // Taps 32, 22, 2, 1. One step per bit taken.
   function automatic logic [31:0] draw(input int nbits);
      logic [31:0] val;
      logic        fb;
      int          k;
      val = '0;
      for (k = 0; k < nbits; k++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         val = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic chance(input int unsigned num16);
      return draw(4) < num16;   // Probability num16 out of 16.
   endfunction

   function automatic logic [11:0] storage_addr(input logic [2:0] k);
      case (k)
         3'd1:    return `CSR_ADDR_MEPC;
         3'd2:    return `CSR_ADDR_MCAUSE;
         3'd3:    return `CSR_ADDR_MTVAL;
         3'd4:    return `CSR_ADDR_MIP;
         3'd5:    return `CSR_ADDR_MTVEC;
         3'd7:    return `CSR_ADDR_MIP;
         default: return `CSR_ADDR_MSCRATCH;
      endcase
   endfunction

   function automatic logic [11:0] known_addr(input logic [2:0] k);
      if (k == 3'd6) return `CSR_ADDR_MCYCLE;
      else if (k == 3'd7) return `CSR_ADDR_MINSTRET;
      else return storage_addr(k);
   endfunction

   function automatic int reg_slot(input logic [11:0] a);
      case (a)
         `CSR_ADDR_MSCRATCH: return 0;
         `CSR_ADDR_MEPC:     return 1;
         `CSR_ADDR_MCAUSE:   return 2;
         `CSR_ADDR_MTVAL:    return 3;
         `CSR_ADDR_MIP:      return 4;
         `CSR_ADDR_MTVEC:    return 5;
         default:            return -1;
      endcase
   endfunction

   function automatic logic [31:0] model_read(input logic [11:0] a);
      int s;
      s = reg_slot(a);
      if (s >= 0) return m_reg[s[2:0]];
      else if (a == `CSR_ADDR_MCYCLE) return m_mcycle;
      else if (a == `CSR_ADDR_MINSTRET) return m_minstret;
      else return '0;
   endfunction

   function automatic string phase_name(input int p);
      case (p)
         1:       return "write_ops";
         2:       return "unknown_addr";
         3:       return "trap";
         4:       return "misalign";
         5:       return "mcycle";
         default: return "minstret";
      endcase
   endfunction

   function automatic int unsigned density(input int p);
      case (p)
         6:       return 1;
         7:       return 3;
         8:       return 7;
         9:       return 12;
         default: return 0;
      endcase
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h at time %0t",
                  name, expected, actual, $time);
      end
   endtask

   // Advances the model over one clock edge.
   task automatic model_edge(input logic [11:0] a, input csr_op_e o, input logic [31:0] d,
                             input trap_t t, input logic pf);
      int   s;
      logic retired;
      s = reg_slot(a);
      if (!t.trap && s >= 0) begin
         case (o)
            op_write: m_reg[s[2:0]] = d;
            op_set:   m_reg[s[2:0]] = m_reg[s[2:0]] | d;
            op_clear: m_reg[s[2:0]] = m_reg[s[2:0]] & ~d;
            default: begin
            end
         endcase
      end
      if (t.trap) begin
         m_reg[S_MEPC]   = t.pc;
         m_reg[S_MCAUSE] = {t.src[4], 27'd0, t.src[3:0]};
      end
      if (t.misalign) m_reg[S_MTVAL] = t.dmem_addr;   // Beats the software write.

      retired = (m_hctr != 2'd3) && !pf && (m_fctr == 2'd0);
      m_mcycle = m_mcycle + 32'd1;
      if (retired) begin
         m_minstret = m_next;
         m_next     = m_next + 32'd1;
      end
      m_fctr = (m_fctr != 2'd0) ? m_fctr + 2'd1 : (pf ? 2'd2 : 2'd0);
      m_hctr = (m_hctr != 2'd0) ? m_hctr + 2'd1 : (data_hazard ? 2'd2 : 2'd0);
   endtask

   // Called just after a rising edge. Drives, steps the model, checks after the next edge.
   task automatic run_cycle(input logic [11:0] a, input csr_op_e o, input logic [31:0] d,
                            input trap_t t, input logic pf, input logic dh);
      logic [31:0] exp_rd;
      logic [31:0] exp_mepc;
      logic [31:0] exp_mtvec;
      addr        = a;
      op          = o;
      wdata       = d;
      trap_info   = t;
      pipe_flush  = pf;
      data_hazard = dh;
      exp_rd    = model_read(a);
      exp_mepc  = m_reg[S_MEPC];
      exp_mtvec = m_reg[S_MTVEC];
      model_edge(a, o, d, t, pf);
      @(posedge clk);
      #1;
      check({test_name, " rdata"}, exp_rd, rdata);
      check({test_name, " mepc_rdata"}, exp_mepc, mepc_rdata);
      check({test_name, " mtvec_rdata"}, exp_mtvec, mtvec_rdata);
   endtask

   task automatic random_cycle(input int phase, input int unsigned dens);
      logic [11:0] a;
      csr_op_e     o;
      trap_t       t;
      logic        pf;
      logic        dh;
      t  = '0;
      pf = 1'b0;
      dh = 1'b0;
      o  = csr_op_e'(2'(draw(2)));
      a  = storage_addr(3'(draw(3)));
      case (phase)
         2: a = chance(8) ? known_addr(3'(draw(3))) : 12'(draw(12));
         3: begin
            t.trap = chance(4);
            t.src  = 5'(draw(5));
            t.pc   = draw(32);
            if (chance(8)) a = chance(8) ? `CSR_ADDR_MEPC : `CSR_ADDR_MCAUSE;
         end
         4: begin
            t.trap      = chance(2);
            t.src       = 5'(draw(5));
            t.pc        = draw(32);
            t.misalign  = chance(6);
            t.dmem_addr = draw(32);
            if (chance(8)) a = `CSR_ADDR_MTVAL;
         end
         5: a = `CSR_ADDR_MCYCLE;
         6: begin
            pf = chance(dens);
            dh = chance(dens);
            a  = chance(12) ? `CSR_ADDR_MINSTRET : `CSR_ADDR_MCYCLE;
         end
         default: begin
         end
      endcase
      run_cycle(a, o, draw(32), t, pf, dh);
   endtask

   task automatic sweep_reads();
      int k;
      for (k = 0; k < 6; k++) begin
         run_cycle(storage_addr(3'(k)), op_nop, '0, '0, 1'b0, 1'b0);
      end
   endtask

   initial begin
      int unsigned exp_cycles;
      int          p;
      int          i;
      addr        = '0;
      op          = op_nop;
      wdata       = '0;
      trap_info   = '0;
      pipe_flush  = 1'b0;
      data_hazard = 1'b0;
      m_reg       = '0;
      m_mcycle    = '0;
      m_minstret  = '0;
      m_next      = 32'd1;
      m_fctr      = 2'd0;
      m_hctr      = 2'd0;
      lfsr_state  = 32'he4ac_8ea8;
      errors      = 0;
      checks      = 0;
      test_name   = "reset";

      @(negedge rst);
      check("reset rdata", '0, rdata);
      check("reset mepc_rdata", '0, mepc_rdata);
      check("reset mtvec_rdata", '0, mtvec_rdata);

      for (p = 1; p <= N_PHASES; p++) begin
         test_name = phase_name(p);
         for (i = 0; i < P_CYCLES; i++) begin
            exp_cycles = edge_count;   // mcycle during this cycle.
            random_cycle(p < 6 ? p : 6, density(p));
            if (p == 5) check("mcycle edges", exp_cycles, rdata);
         end
         sweep_reads();
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   initial begin
      #TIMEOUT;
      $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_file.sv
logic/csr_counters.sv
logic/csr_read.sv
logic/csr_unit.sv
bench/tb_clock.sv
bench/csr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module csr_tb -f flist.f \
   && out="$(./obj_dir/Vcsr_tb)" \
   || { echo "Verilator build or simulation run did not complete"; exit 1; }

echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
